// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = debug_unit_tb
FILES     = debug_unit.f
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)
SOURCES   = $(filter-out +%,$(shell cat $(FILES))) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(FILES) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILES)

run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -q "PASS: all tests"

clean:
	rm -rf $(OBJDIR)

// File: debug_unit.f
+incdir+include
logic/debug_pkg.sv
logic/debug_command_receiver.sv
logic/debug_run_control.sv
logic/debug_frame_sender.sv
logic/debug_unit.sv
sim/debug_unit_checker.sv
sim/debug_unit_tb.sv

// File: include/debug_defs.svh
`ifndef DEBUG_DEFS_SVH
`define DEBUG_DEFS_SVH

// frame prefixes
`define DBG_PREFIX_ERROR 8'h45 // 'E'
`define DBG_PREFIX_INFO  8'h49 // 'I'

`define DBG_NO_CYCLE   8'hFF
`define DBG_NO_ADDRESS 8'hFF

// codes carried in the frame data field
`define DBG_ERR_UNKNOWN_COMMAND 32'd1
`define DBG_ERR_ALREADY_LOADED  32'd2
`define DBG_ERR_MEMORY_FULL     32'd3
`define DBG_ERR_NO_PROGRAM      32'd4
`define DBG_INFO_END_PROGRAM    32'd1

// command characters sent as the first byte of a word
`define DBG_CHAR_L 8'h4C
`define DBG_CHAR_F 8'h46
`define DBG_CHAR_E 8'h45
`define DBG_CHAR_S 8'h53
`define DBG_CHAR_N 8'h4E

`define DBG_HALT_WORD 32'hFC00_0000

`define DBG_REG_COUNT   32
`define DBG_WORD_BYTES  4
`define DBG_FRAME_BYTES 7

`endif

// File: logic/debug_command_receiver.sv
`timescale 1ns/10ps
`include "debug_defs.svh"

module debug_command_receiver
    import debug_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_reset,
    input  logic  i_uart_empty,
    input  byte_t i_uart_data_rd,
    input  logic  i_word_req,
    input  logic  i_step_mode,
    output logic  o_uart_rd,
    output logic  o_word_valid,
    output word_t o_word,
    output cmd_e  o_cmd
);

    logic [1:0] byte_cnt;
    logic       gap;     // cycle after each pop
    logic       hold;    // word delivered and request not yet dropped
    word_t      shift_q;
    word_t      word_in;

    // first byte ends up in the low bits
    assign word_in   = {i_uart_data_rd, shift_q[31:8]};
    assign o_uart_rd = i_word_req && !hold && !gap && !i_uart_empty;
    assign o_word    = shift_q;

    function automatic cmd_e classify(input word_t w, input logic step_mode);
        cmd_e c;
        if (step_mode)
        begin
            case (w)
                {24'h0, `DBG_CHAR_N}: c = CMD_NEXT;
                {24'h0, `DBG_CHAR_S}: c = CMD_STEP;
                default:              c = CMD_UNKNOWN;
            endcase
        end
        else
        begin
            case (w)
                {24'h0, `DBG_CHAR_L}: c = CMD_LOAD;
                {24'h0, `DBG_CHAR_F}: c = CMD_FLUSH;
                {24'h0, `DBG_CHAR_E}: c = CMD_RUN;
                {24'h0, `DBG_CHAR_S}: c = CMD_STEP;
                default:              c = CMD_UNKNOWN;
            endcase
        end
        return c;
    endfunction

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            byte_cnt     <= '0;
            gap          <= 1'b0;
            hold         <= 1'b0;
            o_word_valid <= 1'b0;
        end
        else
        begin
            o_word_valid <= 1'b0;
            gap          <= o_uart_rd;
            if (!i_word_req)
                hold <= 1'b0;
            if (o_uart_rd)
            begin
                byte_cnt <= byte_cnt + 2'd1;
                if (byte_cnt == 2'(`DBG_WORD_BYTES - 1))
                begin
                    o_word_valid <= 1'b1;
                    hold         <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (o_uart_rd)
        begin
            shift_q <= word_in;
            if (byte_cnt == 2'(`DBG_WORD_BYTES - 1))
                o_cmd <= classify(word_in, i_step_mode);
        end
    end

endmodule

// File: logic/debug_frame_sender.sv
`timescale 1ns/10ps
`include "debug_defs.svh"

module debug_frame_sender
    import debug_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_reset,
    input  logic  i_uart_full,
    input  logic  i_frame_start,
    input  byte_t i_frame_prefix,
    input  byte_t i_frame_cycle,
    input  byte_t i_frame_addr,
    input  word_t i_frame_data,
    output logic  o_frame_busy,
    output logic  o_uart_wr,
    output byte_t o_uart_data_wr
);

    logic [8*`DBG_FRAME_BYTES-1:0] frame_q; // data bytes lowest and prefix on top
    logic [2:0]                    byte_cnt;
    logic                          gap;

    assign o_uart_wr      = o_frame_busy && !gap && !i_uart_full;
    assign o_uart_data_wr = frame_q[7:0];

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            o_frame_busy <= 1'b0;
            byte_cnt     <= '0;
            gap          <= 1'b0;
        end
        else
        begin
            gap <= o_uart_wr;
            if (i_frame_start)
            begin
                o_frame_busy <= 1'b1;
                byte_cnt     <= '0;
            end
            else if (o_uart_wr)
                byte_cnt <= byte_cnt + 3'd1;
            else if (gap && byte_cnt == 3'(`DBG_FRAME_BYTES))
                o_frame_busy <= 1'b0; // last byte gone
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_frame_start)
            frame_q <= {i_frame_prefix, i_frame_cycle, i_frame_addr, i_frame_data};
        else if (o_uart_wr)
            frame_q <= {8'h00, frame_q[8*`DBG_FRAME_BYTES-1:8]};
    end

endmodule

// File: logic/debug_pkg.sv
package debug_pkg;

    typedef logic [7:0]    byte_t;
    typedef logic [31:0]   word_t;
    typedef logic [4:0]    reg_index_t;
    typedef logic [1023:0] reg_bank_t; // register 0 in the low bits
    typedef logic [7:0]    step_t;

    typedef enum logic [2:0] {
        CMD_LOAD,
        CMD_FLUSH,
        CMD_RUN,
        CMD_STEP,
        CMD_NEXT,
        CMD_UNKNOWN
    } cmd_e;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        RUN,
        STEP_WAIT,
        STEP_PULSE,
        DUMP,
        REPORT
    } ctrl_state_e;

endpackage

// File: logic/debug_run_control.sv
`timescale 1ns/10ps
`include "debug_defs.svh"

module debug_run_control
    import debug_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_reset,
    input  logic      i_word_valid,
    input  word_t     i_word,
    input  cmd_e      i_cmd,
    input  logic      i_frame_busy,
    input  logic      i_mips_end_program,
    input  logic      i_instruction_memory_empty,
    input  logic      i_instruction_memory_full,
    input  reg_bank_t i_registers,
    output logic      o_word_req,
    output logic      o_step_mode,
    output logic      o_mips_enabled,
    output logic      o_mips_flush,
    output logic      o_mips_clear_program,
    output logic      o_mips_instruction_wr,
    output word_t     o_mips_instruction,
    output logic      o_frame_start,
    output byte_t     o_frame_prefix,
    output byte_t     o_frame_cycle,
    output byte_t     o_frame_addr,
    output word_t     o_frame_data
);

    ctrl_state_e state;
    ctrl_state_e after_report; // where REPORT goes once the frame is out
    step_t       step_count;
    reg_index_t  reg_idx;
    logic        dump_done;
    logic        req_gap;      // request low for a cycle after each word

    logic        send_frame;
    ctrl_state_e send_after;
    byte_t       nxt_prefix;
    byte_t       nxt_cycle;
    byte_t       nxt_addr;
    word_t       nxt_data;

    assign o_word_req  = (state == IDLE || state == LOAD || state == STEP_WAIT) && !req_gap;
    assign o_step_mode = (state == STEP_WAIT);

    // which frame, if any, leaves this cycle
    always_comb
    begin
        send_frame = 1'b0;
        send_after = IDLE;
        nxt_prefix = `DBG_PREFIX_ERROR;
        nxt_cycle  = `DBG_NO_CYCLE;
        nxt_addr   = `DBG_NO_ADDRESS;
        nxt_data   = `DBG_ERR_UNKNOWN_COMMAND;
        case (state)
            IDLE:
                if (i_word_valid)
                begin
                    case (i_cmd)
                        CMD_LOAD:
                        begin
                            send_frame = i_instruction_memory_full || !i_instruction_memory_empty;
                            nxt_data   = i_instruction_memory_full ? `DBG_ERR_MEMORY_FULL
                                                                   : `DBG_ERR_ALREADY_LOADED;
                        end
                        CMD_FLUSH:
                            send_frame = 1'b0;
                        CMD_RUN, CMD_STEP:
                        begin
                            send_frame = i_instruction_memory_empty;
                            nxt_data   = `DBG_ERR_NO_PROGRAM;
                        end
                        default:
                            send_frame = 1'b1;
                    endcase
                end
            STEP_WAIT:
                send_frame = i_word_valid && i_cmd != CMD_NEXT && i_cmd != CMD_STEP;
            RUN:
            begin
                send_frame = i_mips_end_program && !o_mips_flush;
                nxt_prefix = `DBG_PREFIX_INFO;
                nxt_data   = `DBG_INFO_END_PROGRAM;
            end
            DUMP:
            begin
                send_frame = !dump_done || i_mips_end_program;
                nxt_prefix = `DBG_PREFIX_INFO;
                nxt_cycle  = step_count;
                nxt_data   = `DBG_INFO_END_PROGRAM;
                if (!dump_done)
                begin
                    nxt_addr   = {3'b000, reg_idx};
                    nxt_data   = i_registers[reg_idx * $bits(word_t) +: $bits(word_t)];
                    send_after = DUMP;
                end
            end
            default:
                send_frame = 1'b0;
        endcase
    end

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            state                 <= IDLE;
            after_report          <= IDLE;
            step_count            <= '0;
            reg_idx               <= '0;
            dump_done             <= 1'b0;
            req_gap               <= 1'b0;
            o_mips_enabled        <= 1'b0;
            o_mips_flush          <= 1'b0;
            o_mips_clear_program  <= 1'b0;
            o_mips_instruction_wr <= 1'b0;
            o_frame_start         <= 1'b0;
        end
        else
        begin
            req_gap               <= i_word_valid;
            o_mips_flush          <= 1'b0;
            o_mips_clear_program  <= 1'b0;
            o_mips_instruction_wr <= 1'b0;
            o_frame_start         <= 1'b0;
            if (send_frame)
            begin
                o_frame_start  <= 1'b1;
                o_mips_enabled <= 1'b0; // stops a continuous run
                after_report   <= send_after;
                state          <= REPORT;
                dump_done      <= 1'b0;
                if (state == DUMP && !dump_done)
                begin
                    reg_idx   <= reg_idx + 5'd1;
                    dump_done <= (reg_idx == 5'(`DBG_REG_COUNT - 1));
                end
            end
            else
            begin
                case (state)
                    IDLE:
                        if (i_word_valid)
                        begin
                            case (i_cmd)
                                CMD_LOAD:
                                    state <= LOAD;
                                CMD_FLUSH:
                                begin
                                    o_mips_flush         <= 1'b1;
                                    o_mips_clear_program <= 1'b1;
                                end
                                CMD_RUN:
                                begin
                                    o_mips_flush <= 1'b1;
                                    state        <= RUN;
                                end
                                CMD_STEP:
                                begin
                                    o_mips_flush <= 1'b1;
                                    step_count   <= '0;
                                    state        <= STEP_WAIT;
                                end
                                default:
                                    state <= IDLE;
                            endcase
                        end
                    LOAD:
                        if (i_word_valid)
                        begin
                            o_mips_instruction_wr <= 1'b1;
                            if (i_word == `DBG_HALT_WORD)
                                state <= IDLE;
                        end
                    RUN:
                        o_mips_enabled <= 1'b1;
                    STEP_WAIT:
                        if (i_word_valid)
                        begin
                            if (i_cmd == CMD_NEXT)
                            begin
                                step_count     <= step_count + 8'd1;
                                o_mips_enabled <= 1'b1;
                                state          <= STEP_PULSE;
                            end
                            else
                                state <= IDLE; // S leaves step mode
                        end
                    STEP_PULSE:
                    begin
                        o_mips_enabled <= 1'b0;
                        reg_idx        <= '0;
                        state          <= DUMP;
                    end
                    DUMP:
                    begin
                        dump_done <= 1'b0;
                        state     <= STEP_WAIT;
                    end
                    REPORT:
                        if (!o_frame_start && !i_frame_busy)
                            state <= after_report;
                    default:
                        state <= IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (state == LOAD && i_word_valid)
            o_mips_instruction <= i_word;
        if (send_frame)
        begin
            o_frame_prefix <= nxt_prefix;
            o_frame_cycle  <= nxt_cycle;
            o_frame_addr   <= nxt_addr;
            o_frame_data   <= nxt_data;
        end
    end

endmodule

// File: logic/debug_unit.sv
`timescale 1ns/10ps

module debug_unit
    import debug_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_reset,
    input  logic      i_uart_empty,
    input  byte_t     i_uart_data_rd,
    output logic      o_uart_rd,
    input  logic      i_uart_full,
    output logic      o_uart_wr,
    output byte_t     o_uart_data_wr,
    output logic      o_mips_enabled,
    output logic      o_mips_flush,
    output logic      o_mips_clear_program,
    output word_t     o_mips_instruction,
    output logic      o_mips_instruction_wr,
    input  logic      i_mips_end_program,
    input  logic      i_instruction_memory_empty,
    input  logic      i_instruction_memory_full,
    input  reg_bank_t i_registers
);

    logic  word_req;
    logic  step_mode;
    logic  word_valid;
    word_t word;
    cmd_e  cmd;

    logic  frame_start;
    logic  frame_busy;
    byte_t frame_prefix;
    byte_t frame_cycle;
    byte_t frame_addr;
    word_t frame_data;

    debug_command_receiver u_receiver (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_uart_empty   (i_uart_empty),
        .i_uart_data_rd (i_uart_data_rd),
        .i_word_req     (word_req),
        .i_step_mode    (step_mode),
        .o_uart_rd      (o_uart_rd),
        .o_word_valid   (word_valid),
        .o_word         (word),
        .o_cmd          (cmd)
    );

    debug_run_control u_control (
        .i_clk                      (i_clk),
        .i_reset                    (i_reset),
        .i_word_valid               (word_valid),
        .i_word                     (word),
        .i_cmd                      (cmd),
        .i_frame_busy               (frame_busy),
        .i_mips_end_program         (i_mips_end_program),
        .i_instruction_memory_empty (i_instruction_memory_empty),
        .i_instruction_memory_full  (i_instruction_memory_full),
        .i_registers                (i_registers),
        .o_word_req                 (word_req),
        .o_step_mode                (step_mode),
        .o_mips_enabled             (o_mips_enabled),
        .o_mips_flush               (o_mips_flush),
        .o_mips_clear_program       (o_mips_clear_program),
        .o_mips_instruction_wr      (o_mips_instruction_wr),
        .o_mips_instruction         (o_mips_instruction),
        .o_frame_start              (frame_start),
        .o_frame_prefix             (frame_prefix),
        .o_frame_cycle              (frame_cycle),
        .o_frame_addr               (frame_addr),
        .o_frame_data               (frame_data)
    );

    debug_frame_sender u_sender (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_uart_full    (i_uart_full),
        .i_frame_start  (frame_start),
        .i_frame_prefix (frame_prefix),
        .i_frame_cycle  (frame_cycle),
        .i_frame_addr   (frame_addr),
        .i_frame_data   (frame_data),
        .o_frame_busy   (frame_busy),
        .o_uart_wr      (o_uart_wr),
        .o_uart_data_wr (o_uart_data_wr)
    );

endmodule

// File: sim/debug_unit_checker.sv
`timescale 1ns/10ps

module debug_unit_checker
(
    input logic i_clk,
    input logic i_reset,
    input logic i_uart_empty,
    input logic i_uart_rd,
    input logic i_uart_full,
    input logic i_uart_wr,
    input logic i_mips_flush
);

    int unsigned fail_count = 0;

    a_wr_gap: assert property (@(posedge i_clk) disable iff (i_reset)
        i_uart_wr |=> !i_uart_wr)
    else
    begin
        fail_count++;
        $error("uart write strobe high on two cycles in a row");
    end

    a_rd_empty: assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_uart_rd && i_uart_empty))
    else
    begin
        fail_count++;
        $error("uart read strobe while the receive FIFO is empty");
    end

    a_wr_full: assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_uart_wr && i_uart_full))
    else
    begin
        fail_count++;
        $error("uart write strobe while the transmit FIFO is full");
    end

    a_flush_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
        i_mips_flush |=> !i_mips_flush)
    else
    begin
        fail_count++;
        $error("processor flush longer than one cycle");
    end

endmodule

bind debug_unit debug_unit_checker u_checker (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_uart_empty (i_uart_empty),
    .i_uart_rd    (o_uart_rd),
    .i_uart_full  (i_uart_full),
    .i_uart_wr    (o_uart_wr),
    .i_mips_flush (o_mips_flush)
);

// File: sim/debug_unit_tb.sv
`timescale 1ns/10ps
`include "debug_defs.svh"

module debug_unit_tb
    import debug_pkg::*;
();

    logic        i_clk;
    logic        i_reset;
    logic        i_uart_empty = 1'b1;
    byte_t       i_uart_data_rd = 8'h00;
    logic        o_uart_rd;
    logic        i_uart_full = 1'b0;
    logic        o_uart_wr;
    byte_t       o_uart_data_wr;
    logic        o_mips_enabled;
    logic        o_mips_flush;
    logic        o_mips_clear_program;
    word_t       o_mips_instruction;
    logic        o_mips_instruction_wr;
    logic        i_mips_end_program;
    logic        i_instruction_memory_empty = 1'b1;
    logic        i_instruction_memory_full;
    reg_bank_t   i_registers;

    byte_t       rx_q[$];
    byte_t       tx_q[$];
    word_t       instr_q[$];
    int          flush_cnt = 0;
    int          clear_cnt = 0;
    int          enable_cnt = 0;
    logic [31:0] lcg_state = 32'hfe29_04c0;

    debug_unit u_dut (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic reg_bank_t register_pattern();
        reg_bank_t bank;
        for (int k = 0; k < `DBG_REG_COUNT; k++)
            bank[k*32 +: 32] = k * 32'h0101_0101;
        return bank;
    endfunction

    initial
    begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    // receive FIFO model with the byte valid while not empty
    always @(posedge i_clk)
    begin
        if (o_uart_rd)
            void'(rx_q.pop_front());
        i_uart_empty   <= (rx_q.size() == 0);
        i_uart_data_rd <= (rx_q.size() != 0) ? rx_q[0] : 8'h00;
    end

    always @(posedge i_clk)
    begin
        lcg_state = lcg_next(lcg_state);
        i_uart_full <= (lcg_state[31:30] == 2'b00); // roughly one cycle in four
        if (o_uart_wr)
            tx_q.push_back(o_uart_data_wr);
        if (o_mips_instruction_wr)
            instr_q.push_back(o_mips_instruction);
        if (o_mips_clear_program)
            i_instruction_memory_empty <= 1'b1;
        else if (o_mips_instruction_wr)
            i_instruction_memory_empty <= 1'b0;
        if (o_mips_flush)
            flush_cnt++;
        if (o_mips_clear_program)
            clear_cnt++;
        if (o_mips_enabled)
            enable_cnt++;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        if (act !== exp)
            report_failure($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp)
            report_failure($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic send_word(input word_t w);
        for (int b = 0; b < `DBG_WORD_BYTES; b++)
            rx_q.push_back(w[8*b +: 8]); // low byte first
    endtask

    task automatic check_frame(input string name, input byte_t prefix, input byte_t cycle,
                               input byte_t addr, input word_t data);
        int    waited;
        word_t got;
        waited = 0;
        while (tx_q.size() < `DBG_FRAME_BYTES && waited < 4000)
        begin
            @(posedge i_clk);
            waited++;
        end
        if (tx_q.size() < `DBG_FRAME_BYTES)
            report_failure($sformatf("%s: no result frame arrived in time", name));
        for (int b = 0; b < 4; b++)
            got[8*b +: 8] = tx_q.pop_front();
        check_word({name, " data"}, data, got);
        check_byte({name, " address"}, addr, tx_q.pop_front());
        check_byte({name, " cycle"}, cycle, tx_q.pop_front());
        check_byte({name, " prefix"}, prefix, tx_q.pop_front());
    endtask

    task automatic load_program(input string name);
        word_t prog[3];
        int    waited;
        prog = '{32'h2001_0005, 32'h2002_0007, `DBG_HALT_WORD};
        instr_q.delete();
        send_word({24'h0, `DBG_CHAR_L});
        foreach (prog[i])
            send_word(prog[i]);
        waited = 0;
        while (instr_q.size() < 3 && waited < 2000)
        begin
            @(posedge i_clk);
            waited++;
        end
        if (instr_q.size() < 3)
            report_failure($sformatf("%s: program words were not all written", name));
        foreach (prog[i])
            check_word($sformatf("%s word %0d", name, i), prog[i], instr_q.pop_front());
    endtask

    task automatic reset_and_unknown_command();
        check_byte("reset outputs", 8'h00,
                   {2'b00, o_uart_rd, o_uart_wr, o_mips_enabled, o_mips_flush,
                    o_mips_clear_program, o_mips_instruction_wr});
        send_word(32'h0000_0058); // 'X'
        check_frame("unknown command", `DBG_PREFIX_ERROR, `DBG_NO_CYCLE, `DBG_NO_ADDRESS,
                    `DBG_ERR_UNKNOWN_COMMAND);
    endtask

    task automatic load_and_reload();
        load_program("load");
        send_word({24'h0, `DBG_CHAR_L});
        check_frame("second load", `DBG_PREFIX_ERROR, `DBG_NO_CYCLE, `DBG_NO_ADDRESS,
                    `DBG_ERR_ALREADY_LOADED);
        @(posedge i_clk);
        i_instruction_memory_full <= 1'b1;
        send_word({24'h0, `DBG_CHAR_L});
        check_frame("load when full", `DBG_PREFIX_ERROR, `DBG_NO_CYCLE, `DBG_NO_ADDRESS,
                    `DBG_ERR_MEMORY_FULL);
        @(posedge i_clk);
        i_instruction_memory_full <= 1'b0;
    endtask

    task automatic flush_processor(input string name);
        int flush_base;
        int clear_base;
        int waited;
        flush_base = flush_cnt;
        clear_base = clear_cnt;
        send_word({24'h0, `DBG_CHAR_F});
        waited = 0;
        while (flush_cnt == flush_base && waited < 2000)
        begin
            @(posedge i_clk);
            waited++;
        end
        if (flush_cnt == flush_base)
            report_failure($sformatf("%s: the processor was never flushed", name));
        repeat (30) @(posedge i_clk); // window for an unwanted frame
        check_word({name, " flush cycles"}, 32'd1, word_t'(flush_cnt - flush_base));
        check_word({name, " clear cycles"}, 32'd1, word_t'(clear_cnt - clear_base));
        check_word({name, " frame bytes"}, 32'd0, word_t'(tx_q.size()));
    endtask

    task automatic run_to_end();
        int waited;
        send_word({24'h0, `DBG_CHAR_E});
        check_frame("run without program", `DBG_PREFIX_ERROR, `DBG_NO_CYCLE,
                    `DBG_NO_ADDRESS, `DBG_ERR_NO_PROGRAM);
        load_program("run load");
        send_word({24'h0, `DBG_CHAR_E});
        waited = 0;
        while (!o_mips_enabled && waited < 2000)
        begin
            @(posedge i_clk);
            waited++;
        end
        if (!o_mips_enabled)
            report_failure("run: the processor was never enabled");
        @(posedge i_clk);
        i_mips_end_program <= 1'b1;
        check_frame("end of program", `DBG_PREFIX_INFO, `DBG_NO_CYCLE, `DBG_NO_ADDRESS,
                    `DBG_INFO_END_PROGRAM);
        check_byte("enable after end", 8'h00, {7'b0, o_mips_enabled});
        i_mips_end_program <= 1'b0;
    endtask

    task automatic step_and_dump();
        int enable_base;
        enable_base = enable_cnt;
        send_word({24'h0, `DBG_CHAR_S});
        for (int n = 1; n <= 2; n++)
        begin
            send_word({24'h0, `DBG_CHAR_N});
            for (int k = 0; k < `DBG_REG_COUNT; k++)
                check_frame($sformatf("step %0d reg %0d", n, k), `DBG_PREFIX_INFO,
                            byte_t'(n), byte_t'(k), k * 32'h0101_0101);
            check_word($sformatf("step %0d enable cycles", n), word_t'(n),
                       word_t'(enable_cnt - enable_base));
        end
        send_word({24'h0, `DBG_CHAR_S});
        flush_processor("leave step mode"); // an F is only accepted back in IDLE
    endtask

    initial
    begin
        i_reset                   <= 1'b1;
        i_mips_end_program        <= 1'b0;
        i_instruction_memory_full <= 1'b0;
        i_registers               <= register_pattern();
        repeat (3) @(posedge i_clk);
        i_reset <= 1'b0;
        @(posedge i_clk);
        reset_and_unknown_command();
        load_and_reload();
        flush_processor("flush");
        run_to_end();
        step_and_dump();
        if (u_dut.u_checker.fail_count == 0)
        begin
            $display("PASS: all tests");
            $finish;
        end
        else
            report_failure("the bound checker saw assertion failures");
    end

endmodule
